// File: common/pipePkg.sv
// An all-zero idExT, exMemT or memWbT is a bubble; ifIdT needs the NOP word instead
`include "rvDefines.svh"

package pipePkg;
    import rvIsaPkg::*;

    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

    // Fetch to decode
    typedef struct packed {
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] pc;
    } ifIdT;

    // Decode to execute
    typedef struct packed {
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
        logic             memToReg;
        aluOpT            aluOp;
        logic             aluSrcImm;   // Second operand from imm
        logic             isBranch;
        logic             branchOnNe;  // bne rather than beq
        logic             isJump;
        logic             isLui;
        regIdxT           rs1;
        regIdxT           rs2;
        regIdxT           rd;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] pc;
    } idExT;

    // Execute to memory
    typedef struct packed {
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
        logic             memToReg;
        regIdxT           rd;
        logic [`XLEN-1:0] aluResult;  // Also the data address
        logic [`XLEN-1:0] storeData;
    } exMemT;

    // Memory to writeback
    typedef struct packed {
        logic             regWrite;
        regIdxT           rd;
        logic [`XLEN-1:0] wbData;
    } memWbT;

    typedef enum logic [1:0] {
        none,
        fromMem,
        fromWb
    } fwdSelT;

endpackage

// File: common/rvDefines.svh
// RV32I only; XLEN must stay 32 because the decoder assumes 32-bit encodings
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// File: common/rvIsaPkg.sv
// Covers only the opcodes and ALU operations of the supported RV32I subset
package rvIsaPkg;

    // Major opcodes in use
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,  // Signed compare
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluSra = 4'd8
    } aluOpT;

    // Immediate layouts
    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immKindT;

endpackage

// File: decode/instDecoder.sv
// Anything outside the supported RV32I subset decodes to an all-zero bubble
`include "rvDefines.svh"

module instDecoder
    import rvIsaPkg::*;
    import pipePkg::*;
(
    input  logic [`XLEN-1:0] inst,
    output idExT             ctrl,
    output logic [`XLEN-1:0] imm
);

    opcodeT  opcode;
    logic    [2:0] funct3;
    logic    funct7b5;
    immKindT immKind;

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    always_comb begin
        ctrl    = '0;
        immKind = immI;
        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = inst[19:15];
                ctrl.rs2      = inst[24:20];
                ctrl.rd       = inst[11:7];
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b001:  ctrl.aluOp = aluSll;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b100:  ctrl.aluOp = aluXor;
                    3'b101:  ctrl.aluOp = funct7b5 ? aluSra : aluSrl;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    default: ctrl = '0;  // sltu
                endcase
            end
            opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rs1       = inst[19:15];
                ctrl.rd        = inst[11:7];
                case (funct3)
                    3'b000:  ctrl.aluOp = aluAdd;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b100:  ctrl.aluOp = aluXor;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    default: ctrl = '0;  // Shifts by immediate, sltiu
                endcase
            end
            opLui: begin
                immKind        = immU;
                ctrl.regWrite  = 1'b1;
                ctrl.isLui     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rd        = inst[11:7];
            end
            opLoad: begin
                if (funct3 == 3'b010) begin  // lw only
                    ctrl.regWrite  = 1'b1;
                    ctrl.memRead   = 1'b1;
                    ctrl.memToReg  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.rs1       = inst[19:15];
                    ctrl.rd        = inst[11:7];
                end
            end
            opStore: begin
                immKind = immS;
                if (funct3 == 3'b010) begin  // sw only
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.rs1       = inst[19:15];
                    ctrl.rs2       = inst[24:20];
                end
            end
            opBranch: begin
                immKind = immB;
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.isBranch   = 1'b1;
                    ctrl.branchOnNe = funct3[0];
                    ctrl.rs1        = inst[19:15];
                    ctrl.rs2        = inst[24:20];
                end
            end
            opJal: begin
                immKind       = immJ;
                ctrl.regWrite = 1'b1;
                ctrl.isJump   = 1'b1;
                ctrl.rd       = inst[11:7];
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (immKind)
            immS: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            immB: imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                         inst[11:8], 1'b0};
            immU: imm = {inst[31:12], 12'b0};
            immJ: imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                         inst[30:21], 1'b0};
            default: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// File: decode/regFile.sv
// Two combinational read ports, one write port at the clock edge; writes to x0 are dropped
`include "rvDefines.svh"

module regFile
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  regIdxT           rs1,
    input  regIdxT           rs2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  memWbT            wb
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];  // No storage for x0

    // Same-cycle write wins over the stored value
    function automatic logic [`XLEN-1:0] readPort(regIdxT idx);
        if (idx == '0) return '0;
        if (wb.regWrite && wb.rd == idx) return wb.wbData;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.wbData;
        end
    end

    always_comb begin
        rdata1 = readPort(rs1);
        rdata2 = readPort(rs2);
    end

endmodule

// File: execute/executeStage.sv
// Branches and jal resolve here; the redirect target is always PC plus immediate (no jalr)
`include "rvDefines.svh"

module executeStage
    import rvIsaPkg::*;
    import pipePkg::*;
(
    input  idExT             ex,
    input  fwdSelT           fwdA,
    input  fwdSelT           fwdB,
    input  logic [`XLEN-1:0] memFwd,
    input  logic [`XLEN-1:0] wbFwd,
    output exMemT            exOut,
    output logic             redirect,
    output logic [`XLEN-1:0] redirectPc
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic [4:0]       shamt;
    logic             branchTaken;

    function automatic logic [`XLEN-1:0] pickOperand(fwdSelT sel, logic [`XLEN-1:0] regVal,
                                                    logic [`XLEN-1:0] memVal,
                                                    logic [`XLEN-1:0] wbVal);
        case (sel)
            fromMem: return memVal;
            fromWb:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA    = pickOperand(fwdA, ex.rdata1, memFwd, wbFwd);
    assign rs2Val = pickOperand(fwdB, ex.rdata2, memFwd, wbFwd);
    assign opB    = ex.aluSrcImm ? ex.imm : rs2Val;
    assign shamt  = opB[4:0];

    always_comb begin
        case (ex.aluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSll:  aluResult = opA << shamt;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = $signed(opA) >>> shamt;
            default: aluResult = opA + opB;
        endcase
    end

    assign branchTaken = (opA == rs2Val) ^ ex.branchOnNe;
    assign redirect    = ex.isJump || (ex.isBranch && branchTaken);
    assign redirectPc  = ex.pc + ex.imm;

    always_comb begin
        exOut.regWrite  = ex.regWrite;
        exOut.memRead   = ex.memRead;
        exOut.memWrite  = ex.memWrite;
        exOut.memToReg  = ex.memToReg;
        exOut.rd        = ex.rd;
        exOut.storeData = rs2Val;  // Forwarded, not the stale read
        if (ex.isJump) begin
            exOut.aluResult = ex.pc + `XLEN'd4;  // Link value
        end else if (ex.isLui) begin
            exOut.aluResult = ex.imm;
        end else begin
            exOut.aluResult = aluResult;
        end
        // No misaligned-fetch trap in this core
        assert (!redirect || redirectPc[1:0] == 2'b00)
            else $error("redirect to a misaligned target");
    end

endmodule

// File: runSim.sh
#!/bin/sh
# Builds the core and testbench with Verilator, runs it, and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module rvPipeCoreTb -o rvPipeCoreSim
./obj_dir/rvPipeCoreSim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

// File: sim/rvPipeCoreTb.sv
// Memories modeled here with combinational reads; each program must end in a self-jump
`include "rvDefines.svh"

module rvPipeCoreTb;

    localparam int Period      = 100;
    localparam int ResetCycles = 10;
    // Per-test cycle budgets for reset, ALU, load-use, branch, jal and random
    localparam int TestCycles  = 30 + 60 + 40 + 60 + 40 + 200;
    localparam int WatchCycles = TestCycles + 6 * (ResetCycles + 1) + 100;

    typedef enum {rAdd, rSub, rAnd, rOr, rXor, rSlt, rSll, rSrl, rSra} refOpT;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } accessT;

    logic             clk;
    logic             rstN;
    logic [`XLEN-1:0] instAddr;
    logic [`XLEN-1:0] instData;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] dataWData;
    logic             dataWrEn;
    logic             dataRdEn;
    logic [`XLEN-1:0] dataRData;

    logic [`XLEN-1:0] imem  [512];
    logic [`XLEN-1:0] dmem  [1024];
    logic [`XLEN-1:0] model [32];   // Architectural register state
    logic [`XLEN-1:0] pcPtr;
    logic [`XLEN-1:0] endPc;
    accessT           expStores[$];
    accessT           gotStores[$];
    accessT           expLoads[$];
    accessT           gotLoads[$];
    int               errors;
    int               seed;

    rvPipeCore dut (
        .clk(clk), .rstN(rstN), .instAddr(instAddr), .instData(instData),
        .dataAddr(dataAddr), .dataWData(dataWData), .dataWrEn(dataWrEn),
        .dataRdEn(dataRdEn), .dataRData(dataRData)
    );

    assign instData  = imem[instAddr[10:2]];
    assign dataRData = dmem[dataAddr[11:2]];

    always #(Period / 2) clk = ~clk;

    // Data port traffic, one record per cycle
    always @(negedge clk) begin
        if (dataWrEn) begin
            gotStores.push_back('{addr: dataAddr, data: dataWData});
            dmem[dataAddr[11:2]] = dataWData;
        end
        if (dataRdEn) gotLoads.push_back('{addr: dataAddr, data: dataRData});
    end

    task automatic checkValue(string what, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [`XLEN-1:0] sext12(logic [11:0] v);
        return {{(`XLEN-12){v[11]}}, v};
    endfunction

    function automatic logic [2:0] funct3Of(refOpT op);
        case (op)
            rSll:       return 3'b001;
            rSlt:       return 3'b010;
            rXor:       return 3'b100;
            rSrl, rSra: return 3'b101;
            rOr:        return 3'b110;
            rAnd:       return 3'b111;
            default:    return 3'b000;
        endcase
    endfunction

    // RV32I result of one operation
    function automatic logic [`XLEN-1:0] aluModel(refOpT op, logic [`XLEN-1:0] a,
                                                  logic [`XLEN-1:0] b);
        case (op)
            rSub:    return a - b;
            rAnd:    return a & b;
            rOr:     return a | b;
            rXor:    return a ^ b;
            rSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rSll:    return a << b[4:0];
            rSrl:    return a >> b[4:0];
            rSra:    return $signed(a) >>> b[4:0];
            default: return a + b;
        endcase
    endfunction

    task automatic setReg(logic [4:0] rd, logic [`XLEN-1:0] v);
        if (rd != 5'd0) model[rd] = v;
    endtask

    task automatic emit(logic [`XLEN-1:0] inst);
        imem[pcPtr[10:2]] = inst;
        pcPtr = pcPtr + 32'd4;
    endtask

    task automatic emitRR(refOpT op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        logic f7b5;
        f7b5 = (op == rSub) || (op == rSra);
        emit({1'b0, f7b5, 5'b0, rs2, rs1, funct3Of(op), rd, 7'b0110011});
        setReg(rd, aluModel(op, model[rs1], model[rs2]));
    endtask

    task automatic emitRI(refOpT op, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        emit({imm, rs1, funct3Of(op), rd, 7'b0010011});
        setReg(rd, aluModel(op, model[rs1], sext12(imm)));
    endtask

    task automatic emitLui(logic [4:0] rd, logic [19:0] imm);
        emit({imm, rd, 7'b0110111});
        setReg(rd, {imm, 12'b0});
    endtask

    task automatic emitLw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] off);
        logic [`XLEN-1:0] addr;
        addr = model[rs1] + sext12(off);
        emit({off, rs1, 3'b010, rd, 7'b0000011});
        expLoads.push_back('{addr: addr, data: dmem[addr[11:2]]});
        setReg(rd, dmem[addr[11:2]]);
    endtask

    // live is low for a store that must never reach memory
    task automatic emitSw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off, logic live);
        emit({off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011});
        if (live) expStores.push_back('{addr: model[rs1] + sext12(off), data: model[rs2]});
    endtask

    task automatic emitBranch(logic ne, logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off,
                              output logic taken);
        emit({off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011});
        taken = (model[rs1] == model[rs2]) ^ ne;
    endtask

    task automatic emitJal(logic [4:0] rd, logic [20:0] off);
        setReg(rd, pcPtr + 32'd4);
        emit({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111});
    endtask

    task automatic emitEnd();
        endPc = pcPtr;
        emitJal(5'd0, 21'd0);
    endtask

    // Core held in reset while a new program and fresh memory go in
    task automatic holdReset();
        @(negedge clk);
        rstN = 1'b0;
        for (int i = 0; i < 512; i++) imem[i] = `NOP_INST;
        for (int i = 0; i < 1024; i++) dmem[i] = 32'hA5A5_0000 ^ (i * 32'h0004_0021);
        for (int i = 0; i < 32; i++) model[i] = '0;
        pcPtr = `RESET_PC;
        expStores.delete();
        gotStores.delete();
        expLoads.delete();
        gotLoads.delete();
    endtask

    task automatic compareAccesses(string what, accessT got[$], accessT exp[$]);
        if (got.size() != exp.size()) begin
            errors++;
            $display("%s: %0d accesses seen but %0d expected, some are missing or extra",
                     what, got.size(), exp.size());
        end
        for (int i = 0; i < got.size() && i < exp.size(); i++) begin
            checkValue($sformatf("%s %0d address", what, i), got[i].addr, exp[i].addr);
            checkValue($sformatf("%s %0d data", what, i), got[i].data, exp[i].data);
        end
    endtask

    task automatic runProgram(string name, logic startupCheck);
        repeat (ResetCycles) begin
            @(negedge clk);
            checkValue("instAddr in reset", instAddr, `RESET_PC);
            checkValue("dataWrEn in reset", {31'b0, dataWrEn}, '0);
            checkValue("dataRdEn in reset", {31'b0, dataRdEn}, '0);
        end
        rstN = 1'b1;
        if (startupCheck) begin
            for (int k = 1; k <= 3; k++) begin
                @(negedge clk);
                checkValue("instAddr after reset", instAddr, `RESET_PC + 32'(4 * k));
                checkValue("dataWrEn after reset", {31'b0, dataWrEn}, '0);
                checkValue("dataRdEn after reset", {31'b0, dataRdEn}, '0);
            end
        end
        // Second arrival at the self-jump means it has executed
        while (instAddr != endPc) @(negedge clk);
        while (instAddr == endPc) @(negedge clk);
        while (instAddr != endPc) @(negedge clk);
        compareAccesses({name, " store"}, gotStores, expStores);
        compareAccesses({name, " load"}, gotLoads, expLoads);
    endtask

    task automatic testReset();
        holdReset();
        repeat (6) emit(`NOP_INST);
        emitEnd();
        runProgram("reset", 1'b1);
    endtask

    task automatic testAluChain();
        holdReset();
        emitLui(5'd1, 20'h12345);
        emitRI(rAdd, 5'd2, 5'd1, 12'h678);
        emitRR(rSub, 5'd3, 5'd2, 5'd1);
        emitRR(rXor, 5'd4, 5'd3, 5'd2);
        emitRI(rAdd, 5'd5, 5'd0, 12'd4);
        emitRR(rSll, 5'd6, 5'd2, 5'd5);
        emitLui(5'd7, 20'hF0F0F);
        emitRR(rSra, 5'd8, 5'd7, 5'd5);
        emitRR(rSrl, 5'd9, 5'd7, 5'd5);
        emitRR(rSlt, 5'd10, 5'd7, 5'd1);
        emitRR(rAnd, 5'd11, 5'd6, 5'd7);
        emitRR(rOr, 5'd12, 5'd11, 5'd4);
        emitRI(rAnd, 5'd13, 5'd12, 12'h0F0);
        emitRI(rOr, 5'd14, 5'd13, 12'h801);
        emitRI(rXor, 5'd15, 5'd14, 12'hFFF);
        emitRI(rSlt, 5'd16, 5'd15, 12'h7FF);
        emitRR(rAdd, 5'd17, 5'd16, 5'd15);
        for (int r = 17; r >= 1; r--) emitSw(5'(r), 5'd0, 12'h100 + 12'(4 * r), 1'b1);
        emitEnd();
        runProgram("alu", 1'b0);
    endtask

    task automatic testLoadUse();
        holdReset();
        emitRI(rAdd, 5'd1, 5'd0, 12'h040);
        emitRI(rAdd, 5'd2, 5'd0, 12'h123);
        emitLw(5'd3, 5'd1, 12'h008);
        emitRR(rAdd, 5'd4, 5'd3, 5'd2);  // Needs the loaded word at once
        emitSw(5'd4, 5'd1, 12'h020, 1'b1);
        emitLw(5'd5, 5'd1, 12'h00C);
        emitSw(5'd5, 5'd0, 12'h200, 1'b1);
        emitEnd();
        runProgram("load-use", 1'b0);
    endtask

    task automatic branchCase(logic ne, logic [4:0] rs1, logic [4:0] rs2, logic [11:0] base);
        logic taken;
        emitBranch(ne, rs1, rs2, 13'd12, taken);
        emitSw(rs1, 5'd0, base, !taken);
        emitSw(rs2, 5'd0, base + 12'd4, !taken);
    endtask

    task automatic testBranches();
        holdReset();
        emitRI(rAdd, 5'd1, 5'd0, 12'd5);
        emitRI(rAdd, 5'd2, 5'd0, 12'd5);
        emitRI(rAdd, 5'd3, 5'd0, 12'd7);
        branchCase(1'b0, 5'd1, 5'd2, 12'h200);  // beq taken
        branchCase(1'b1, 5'd1, 5'd3, 12'h208);  // bne taken
        branchCase(1'b0, 5'd1, 5'd3, 12'h210);
        branchCase(1'b1, 5'd1, 5'd2, 12'h218);
        emitEnd();
        runProgram("branch", 1'b0);
    endtask

    task automatic testJal();
        holdReset();
        emitRI(rAdd, 5'd1, 5'd0, 12'd77);
        emitJal(5'd5, 21'd8);
        emitSw(5'd1, 5'd0, 12'h300, 1'b0);
        emitSw(5'd5, 5'd0, 12'h304, 1'b1);
        emitEnd();
        runProgram("jal", 1'b0);
    endtask

    task automatic testRandomOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] base;
        holdReset();
        for (int i = 0; i < 20; i++) begin
            a    = $random(seed);
            b    = $random(seed);
            base = 12'h400 + 12'(i * 12);
            emitRI(rAdd, 5'd1, 5'd0, a[11:0]);
            emitRI(rXor, 5'd2, 5'd1, b[11:0]);
            emitRR(rSlt, 5'd3, 5'd1, 5'd2);
            emitSw(5'd1, 5'd0, base, 1'b1);
            emitSw(5'd2, 5'd0, base + 12'd4, 1'b1);
            emitSw(5'd3, 5'd0, base + 12'd8, 1'b1);
        end
        emitEnd();
        runProgram("random", 1'b0);
    endtask

    initial begin
        #(WatchCycles * Period);
        $display("Watchdog expired: the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk    = 1'b0;
        rstN   = 1'b0;
        errors = 0;
        seed   = 18;
        pcPtr  = `RESET_PC;
        endPc  = `RESET_PC;
        for (int i = 0; i < 512; i++) imem[i] = `NOP_INST;
        for (int i = 0; i < 1024; i++) dmem[i] = '0;
        testReset();
        testAluChain();
        testLoadUse();
        testBranches();
        testJal();
        testRandomOps();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: source/hazardUnit.sv
// One-bubble load-use stall only; forwarding assumes MEM-stage load data is ready in the same cycle
module hazardUnit
    import pipePkg::*;
(
    input  regIdxT idRs1,
    input  regIdxT idRs2,
    input  idExT   ex,
    input  exMemT  exMem,
    input  memWbT  memWb,
    input  logic   redirect,
    output logic   pcStall,
    output logic   ifIdStall,
    output logic   ifIdFlush,
    output logic   idExFlush,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    logic loadUse;

    // Youngest producer wins
    function automatic fwdSelT pickFwd(regIdxT src, exMemT m, memWbT w);
        if (src == '0) return none;
        if (m.regWrite && m.rd == src) return fromMem;
        if (w.regWrite && w.rd == src) return fromWb;
        return none;
    endfunction

    // Load in EX feeding the instruction in ID
    assign loadUse = ex.memRead && (ex.rd != '0)
                     && ((ex.rd == idRs1) || (ex.rd == idRs2));

    assign pcStall   = loadUse;
    assign ifIdStall = loadUse;
    assign ifIdFlush = redirect;              // Kill the fetched shadow
    assign idExFlush = loadUse || redirect;   // Bubble or kill the decoded shadow

    assign fwdA = pickFwd(ex.rs1, exMem, memWb);
    assign fwdB = pickFwd(ex.rs2, exMem, memWb);

endmodule

// File: source/pipeStageReg.sv
// Flush beats stall; reset and flush both load flushValue, so pick a bubble-safe value
module pipeStageReg
    import pipePkg::*;
#(
    parameter type     payloadT   = ifIdT,
    parameter payloadT flushValue = '0
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= flushValue;
        end else if (flush) begin
            q <= flushValue;  // Younger instruction squashed
        end else if (!stall) begin
            q <= d;
        end
    end

    // Hazard levels come from another module and must be clean once running
    ctrlKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({stall, flush}))
        else $error("stage register stall/flush unknown");

endmodule

// File: source/rvPipeCore.sv
// Memories are external with combinational read data and no wait states; word accesses only
`include "rvDefines.svh"

module rvPipeCore
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    output logic [`XLEN-1:0] instAddr,
    input  logic [`XLEN-1:0] instData,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWData,
    output logic             dataWrEn,
    output logic             dataRdEn,
    input  logic [`XLEN-1:0] dataRData
);

    localparam ifIdT IfIdBubble = '{inst: `NOP_INST, pc: `RESET_PC};

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcNext;
    logic [`XLEN-1:0] redirectPc;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] decImm;
    logic             redirect;
    logic             pcStall;
    logic             ifIdStall;
    logic             ifIdFlush;
    logic             idExFlush;
    fwdSelT           fwdA;
    fwdSelT           fwdB;
    ifIdT             ifIdD, ifIdQ;
    idExT             decCtrl;
    idExT             idExD, idExQ;
    exMemT            exMemD, exMemQ;
    memWbT            memWbD, memWbQ;

    // Redirect outranks the load-use hold
    always_comb begin
        if (redirect) pcNext = redirectPc;
        else if (pcStall) pcNext = pc;
        else pcNext = pc + `XLEN'd4;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) pc <= `RESET_PC;
        else pc <= pcNext;
    end

    assign instAddr = pc;
    assign ifIdD    = '{inst: instData, pc: pc};

    pipeStageReg #(.payloadT(ifIdT), .flushValue(IfIdBubble)) ifIdReg (
        .clk(clk), .rstN(rstN), .stall(ifIdStall), .flush(ifIdFlush), .d(ifIdD), .q(ifIdQ)
    );

    instDecoder decoder (.inst(ifIdQ.inst), .ctrl(decCtrl), .imm(decImm));

    regFile regs (
        .clk(clk), .rstN(rstN), .rs1(decCtrl.rs1), .rs2(decCtrl.rs2),
        .rdata1(rdata1), .rdata2(rdata2), .wb(memWbQ)
    );

    always_comb begin
        idExD        = decCtrl;
        idExD.rdata1 = rdata1;
        idExD.rdata2 = rdata2;
        idExD.imm    = decImm;
        idExD.pc     = ifIdQ.pc;
    end

    pipeStageReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(idExFlush), .d(idExD), .q(idExQ)
    );

    executeStage execute (
        .ex(idExQ), .fwdA(fwdA), .fwdB(fwdB), .memFwd(memWbD.wbData), .wbFwd(memWbQ.wbData),
        .exOut(exMemD), .redirect(redirect), .redirectPc(redirectPc)
    );

    pipeStageReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    assign dataAddr  = exMemQ.aluResult;
    assign dataWData = exMemQ.storeData;
    assign dataWrEn  = exMemQ.memWrite;
    assign dataRdEn  = exMemQ.memRead;

    // Load data chosen here so it can forward straight from MEM
    assign memWbD = '{regWrite: exMemQ.regWrite, rd: exMemQ.rd,
                      wbData: exMemQ.memToReg ? dataRData : exMemQ.aluResult};

    pipeStageReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    hazardUnit hazards (
        .idRs1(decCtrl.rs1), .idRs2(decCtrl.rs2), .ex(idExQ), .exMem(exMemQ), .memWb(memWbQ),
        .redirect(redirect), .pcStall(pcStall), .ifIdStall(ifIdStall),
        .ifIdFlush(ifIdFlush), .idExFlush(idExFlush), .fwdA(fwdA), .fwdB(fwdB)
    );

endmodule

// File: src.f
+incdir+common
common/rvIsaPkg.sv
common/pipePkg.sv
source/pipeStageReg.sv
decode/instDecoder.sv
decode/regFile.sv
execute/executeStage.sv
source/hazardUnit.sv
source/rvPipeCore.sv
sim/rvPipeCoreTb.sv
